//--- logic/mem_arbiter.sv
/*
 * Round-robin arbiter between fetch and load/store
 * Builds one SRAM command per cycle from the winning port
 */
`timescale 1ns/100ps
`include "mem_subsys_config.svh"

module mem_arbiter import mem_subsys_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic       i_req_i,
  input  instr_req_t i_data_i,
  input  logic       d_req_i,
  input  data_req_t  d_data_i,
  output logic       i_gnt_o,
  output logic       d_gnt_o,
  output sram_cmd_t  cmd_o
);

  // High when data wins the next conflict
  logic data_prio_q;
  logic conflict;

  assign conflict = i_req_i & d_req_i;

  assign d_gnt_o = d_req_i & (~i_req_i | data_prio_q);
  assign i_gnt_o = i_req_i & (~d_req_i | ~data_prio_q);

  // Loser of a conflict takes the next one
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_prio_q <= 1'b1;
    end else if (conflict) begin
      data_prio_q <= ~data_prio_q;
    end
  end

  // Fetches become plain reads at the word index of their byte address
  always_comb begin
    cmd_o.en = i_gnt_o | d_gnt_o;
    if (d_gnt_o) begin
      cmd_o.we    = d_data_i.we;
      cmd_o.be    = d_data_i.be;
      cmd_o.idx   = d_data_i.addr[`MEM_IDX_W+1:2];
      cmd_o.wdata = d_data_i.wdata;
    end else begin
      cmd_o.we    = 1'b0;
      cmd_o.be    = '1;
      cmd_o.idx   = i_data_i.addr[`MEM_IDX_W+1:2];
      cmd_o.wdata = '0;
    end
  end

  a_one_grant : assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(i_gnt_o && d_gnt_o)
  );

endmodule

//--- logic/mem_port.sv
/*
 * Bus port controller
 * Range check, local error answers and the one-cycle response
 */
`timescale 1ns/100ps
`include "mem_subsys_config.svh"

module mem_port import mem_subsys_pkg::*; #(
  parameter type req_t = instr_req_t
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_i,
  input  req_t                   req_data_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output mem_rsp_t               rsp_o,
  output logic                   fwd_req_o,
  output req_t                   fwd_data_o,
  input  logic                   fwd_gnt_i,
  input  logic [`MEM_DATA_W-1:0] sram_rdata_i
);

  // First byte address past the SRAM
  localparam logic [`MEM_ADDR_W-1:0] ADDR_LIMIT = `MEM_ADDR_W'(4 * `MEM_WORDS);

  logic in_range;
  logic rvalid_q;
  logic err_q;

  assign in_range = (req_data_i.addr < ADDR_LIMIT);

  // Only in-range accesses reach the arbiter
  assign fwd_req_o  = req_i & in_range;
  assign fwd_data_o = req_data_i;

  // Out-of-range requests are accepted at once
  assign gnt_o = req_i & (in_range ? fwd_gnt_i : 1'b1);

  // Remember what the granted access was for the response cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
      err_q    <= gnt_o & ~in_range;
    end
  end

  assign rvalid_o = rvalid_q;

  // SRAM word lands in the same cycle, errors carry zero data
  always_comb begin
    rsp_o.err   = err_q;
    rsp_o.rdata = err_q ? '0 : sram_rdata_i;
  end

  // Requester holds its request until granted
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (req_i && !gnt_o) |=> (req_i && $stable(req_data_i))
  );

  // Every response belongs to a grant one cycle earlier
  a_rvalid_after_gnt : assert property (
    @(posedge clk_i) disable iff (rst_i)
    rvalid_o |-> $past(gnt_o)
  );

endmodule

//--- logic/mem_sram.sv
/*
 * Single-port word SRAM
 * Byte-enabled writes and a registered read port
 */
`timescale 1ns/100ps
`include "mem_subsys_config.svh"

module mem_sram import mem_subsys_pkg::*; (
  input  logic                   clk_i,
  input  sram_cmd_t              cmd_i,
  output logic [`MEM_DATA_W-1:0] rdata_o
);

  localparam int unsigned NBYTES = `MEM_DATA_W / 8;

  logic [`MEM_DATA_W-1:0] mem_q [`MEM_WORDS];
  logic [`MEM_DATA_W-1:0] rdata_q;

  // Write lanes selected by be
  always_ff @(posedge clk_i) begin
    if (cmd_i.en && cmd_i.we) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (cmd_i.be[b]) begin
          mem_q[cmd_i.idx][b*8 +: 8] <= cmd_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read data valid the cycle after en, held otherwise
  always_ff @(posedge clk_i) begin
    if (cmd_i.en && !cmd_i.we) begin
      rdata_q <= mem_q[cmd_i.idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- logic/mem_subsys_config.svh
/*
 * Memory subsystem configuration
 * Bus widths, SRAM depth and the accepted byte address range
 */
`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// Bus data width in bits
`define MEM_DATA_W 32

// Byte address width in bits
`define MEM_ADDR_W 32

// SRAM depth in words, valid bytes are 0 .. 4*MEM_WORDS-1
`define MEM_WORDS 256

// Word index width, log2 of MEM_WORDS
`define MEM_IDX_W 8

`endif

//--- logic/mem_subsys_pkg.sv
/*
 * Memory subsystem types
 * Bus requests, responses and the SRAM command word
 */
`include "mem_subsys_config.svh"

package mem_subsys_pkg;

  // Instruction fetch request, read only
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
  } instr_req_t;

  // Data load/store request
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0]   addr;
    logic                     we;
    logic [`MEM_DATA_W/8-1:0] be;
    logic [`MEM_DATA_W-1:0]   wdata;
  } data_req_t;

  // Response returned with rvalid
  typedef struct packed {
    logic [`MEM_DATA_W-1:0] rdata;
    logic                   err;
  } mem_rsp_t;

  // One SRAM access per cycle
  typedef struct packed {
    logic                     en;
    logic                     we;
    logic [`MEM_DATA_W/8-1:0] be;
    logic [`MEM_IDX_W-1:0]    idx;
    logic [`MEM_DATA_W-1:0]   wdata;
  } sram_cmd_t;

endpackage

//--- logic/mem_subsys_top.sv
/*
 * Memory subsystem top
 * Fetch and load/store ports sharing one SRAM through an arbiter
 */
`timescale 1ns/100ps
`include "mem_subsys_config.svh"

module mem_subsys_top import mem_subsys_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  // Instruction fetch port
  input  logic       instr_req_i,
  input  instr_req_t instr_data_i,
  output logic       instr_gnt_o,
  output logic       instr_rvalid_o,
  output mem_rsp_t   instr_rsp_o,
  // Data load/store port
  input  logic       data_req_i,
  input  data_req_t  data_data_i,
  output logic       data_gnt_o,
  output logic       data_rvalid_o,
  output mem_rsp_t   data_rsp_o
);

  logic                   i_fwd_req;
  instr_req_t             i_fwd_data;
  logic                   i_fwd_gnt;
  logic                   d_fwd_req;
  data_req_t              d_fwd_data;
  logic                   d_fwd_gnt;
  sram_cmd_t              sram_cmd;
  logic [`MEM_DATA_W-1:0] sram_rdata;

  mem_port #(.req_t(instr_req_t)) u_instr_port (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (instr_req_i),
    .req_data_i   (instr_data_i),
    .gnt_o        (instr_gnt_o),
    .rvalid_o     (instr_rvalid_o),
    .rsp_o        (instr_rsp_o),
    .fwd_req_o    (i_fwd_req),
    .fwd_data_o   (i_fwd_data),
    .fwd_gnt_i    (i_fwd_gnt),
    .sram_rdata_i (sram_rdata)
  );

  mem_port #(.req_t(data_req_t)) u_data_port (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (data_req_i),
    .req_data_i   (data_data_i),
    .gnt_o        (data_gnt_o),
    .rvalid_o     (data_rvalid_o),
    .rsp_o        (data_rsp_o),
    .fwd_req_o    (d_fwd_req),
    .fwd_data_o   (d_fwd_data),
    .fwd_gnt_i    (d_fwd_gnt),
    .sram_rdata_i (sram_rdata)
  );

  mem_arbiter u_arbiter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .i_req_i  (i_fwd_req),
    .i_data_i (i_fwd_data),
    .d_req_i  (d_fwd_req),
    .d_data_i (d_fwd_data),
    .i_gnt_o  (i_fwd_gnt),
    .d_gnt_o  (d_fwd_gnt),
    .cmd_o    (sram_cmd)
  );

  mem_sram u_sram (
    .clk_i   (clk_i),
    .cmd_i   (sram_cmd),
    .rdata_o (sram_rdata)
  );

endmodule

//--- mem_subsys_top.f
+incdir+logic
logic/mem_subsys_pkg.sv
logic/mem_port.sv
logic/mem_arbiter.sv
logic/mem_sram.sv
logic/mem_subsys_top.sv
verif/mem_subsys_tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
TOP=mem_subsys_tb_top

verilator --binary --timing --assert \
  -f mem_subsys_top.f \
  --top-module "$TOP" \
  -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# The log decides, the exit status only backs it up
if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0

//--- verif/mem_subsys_tb_top.sv
/*
 * Memory subsystem testbench
 * Random fetch and load/store traffic checked against a word model
 */
`timescale 1ns/100ps
`include "mem_subsys_config.svh"

module mem_subsys_tb_top import mem_subsys_pkg::*; ;

  localparam int RAND_REQS      = 300;
  localparam int IDLE_CYCLES    = 6;
  localparam int TOTAL_REQS     = `MEM_WORDS + 2 * RAND_REQS;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_REQS + 100;

  logic       clk_i;
  logic       rst_i;
  logic       instr_req_i;
  instr_req_t instr_data_i;
  logic       instr_gnt_o;
  logic       instr_rvalid_o;
  mem_rsp_t   instr_rsp_o;
  logic       data_req_i;
  data_req_t  data_data_i;
  logic       data_gnt_o;
  logic       data_rvalid_o;
  mem_rsp_t   data_rsp_o;

  // Reference memory and arbitration state
  logic [`MEM_DATA_W-1:0] model_mem [`MEM_WORDS];
  logic                   data_first;
  logic                   i_pend;
  logic                   d_pend;
  logic                   d_chk_rdata;
  mem_rsp_t               i_exp;
  mem_rsp_t               d_exp;
  logic [31:0]            lcg_state;
  int                     cycle_cnt;
  int                     n_conflicts;
  int                     n_oor;

  mem_subsys_top i_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_req_i    (instr_req_i),
    .instr_data_i   (instr_data_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rsp_o    (instr_rsp_o),
    .data_req_i     (data_req_i),
    .data_data_i    (data_data_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rsp_o     (data_rsp_o)
  );

  always #4 clk_i = ~clk_i;

  // Upper state bits moved down, the low LCG bits repeat too quickly
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] addr);
    return addr < `MEM_ADDR_W'(4 * `MEM_WORDS);
  endfunction

  // One in eight addresses lands above the SRAM, with low bits that alias a word
  function automatic logic [31:0] pick_addr(input logic [31:0] r);
    if (r[2:0] == 3'd0) begin
      return {r[31:10] | 22'd1, r[9:2], 2'b00};
    end
    return {22'd0, r[17:10], 2'b00};
  endfunction

  function automatic logic [31:0] fill_word(input int unsigned idx);
    return 32'h9E37_79B9 * (idx + 32'd1) ^ 32'h0F0F_0F0F;
  endfunction

  task automatic compare_values(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // Issues requests on both ports, holding each one until its grant
  task automatic run_traffic(input int n_instr, input int n_data, input logic fill);
    int          i_left;
    int          d_left;
    int          fill_idx;
    logic        i_active;
    logic        d_active;
    logic [31:0] r;
    i_left   = n_instr;
    d_left   = n_data;
    fill_idx = 0;
    i_active = 1'b0;
    d_active = 1'b0;
    while (i_left > 0 || d_left > 0 || i_active || d_active) begin
      @(posedge clk_i);
      if (i_active && instr_gnt_o) begin
        i_active = 1'b0;
      end
      if (d_active && data_gnt_o) begin
        d_active = 1'b0;
      end
      if (!i_active) begin
        r = lcg_next();
        if (i_left > 0 && r[1:0] != 2'b00) begin
          instr_req_i       <= 1'b1;
          instr_data_i.addr <= pick_addr(lcg_next());
          i_active = 1'b1;
          i_left--;
        end else begin
          instr_req_i <= 1'b0;
        end
      end
      if (!d_active) begin
        r = lcg_next();
        if (d_left > 0 && (fill || r[1:0] != 2'b00)) begin
          data_req_i <= 1'b1;
          if (fill) begin
            // Back-to-back full-word writes over the whole SRAM
            data_data_i.addr  <= 32'(fill_idx * 4);
            data_data_i.we    <= 1'b1;
            data_data_i.be    <= 4'hF;
            data_data_i.wdata <= fill_word(fill_idx);
            fill_idx++;
          end else begin
            data_data_i.addr  <= pick_addr(lcg_next());
            data_data_i.we    <= r[2];
            data_data_i.be    <= r[7:4];
            data_data_i.wdata <= lcg_next();
          end
          d_active = 1'b1;
          d_left--;
        end else begin
          data_req_i <= 1'b0;
        end
      end
    end
  endtask

  // Grants and responses sampled at each edge for the cycle just ended
  always @(posedge clk_i) begin
    logic                  i_in;
    logic                  d_in;
    logic                  i_fwd;
    logic                  d_fwd;
    logic                  exp_i_gnt;
    logic                  exp_d_gnt;
    logic [`MEM_IDX_W-1:0] idx;
    if (!rst_i) begin
      compare_values("instr_rvalid_o", 64'(instr_rvalid_o), 64'(i_pend));
      if (i_pend) begin
        compare_values("instr_rsp_o.err", 64'(instr_rsp_o.err), 64'(i_exp.err));
        compare_values("instr_rsp_o.rdata", 64'(instr_rsp_o.rdata), 64'(i_exp.rdata));
      end
      compare_values("data_rvalid_o", 64'(data_rvalid_o), 64'(d_pend));
      if (d_pend) begin
        compare_values("data_rsp_o.err", 64'(data_rsp_o.err), 64'(d_exp.err));
        if (d_chk_rdata) begin
          compare_values("data_rsp_o.rdata", 64'(data_rsp_o.rdata), 64'(d_exp.rdata));
        end
      end

      // Out-of-range goes straight through, in-range follows round robin
      i_in      = in_range(instr_data_i.addr);
      d_in      = in_range(data_data_i.addr);
      i_fwd     = instr_req_i && i_in;
      d_fwd     = data_req_i && d_in;
      exp_i_gnt = instr_req_i && (!i_in || !d_fwd || !data_first);
      exp_d_gnt = data_req_i && (!d_in || !i_fwd || data_first);
      compare_values("instr_gnt_o", 64'(instr_gnt_o), 64'(exp_i_gnt));
      compare_values("data_gnt_o", 64'(data_gnt_o), 64'(exp_d_gnt));
      if (i_fwd && d_fwd) begin
        n_conflicts++;
        data_first = instr_gnt_o;
      end

      i_pend = instr_gnt_o;
      if (instr_gnt_o) begin
        if (!i_in) begin
          i_exp.err   = 1'b1;
          i_exp.rdata = '0;
          n_oor++;
        end else begin
          idx         = instr_data_i.addr[`MEM_IDX_W+1:2];
          i_exp.err   = 1'b0;
          i_exp.rdata = model_mem[idx];
        end
      end

      d_pend = data_gnt_o;
      if (data_gnt_o) begin
        d_chk_rdata = 1'b1;
        if (!d_in) begin
          d_exp.err   = 1'b1;
          d_exp.rdata = '0;
          n_oor++;
        end else begin
          idx       = data_data_i.addr[`MEM_IDX_W+1:2];
          d_exp.err = 1'b0;
          if (data_data_i.we) begin
            // Write response carries no data
            d_chk_rdata = 1'b0;
            for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
              if (data_data_i.be[b]) begin
                model_mem[idx][b*8 +: 8] = data_data_i.wdata[b*8 +: 8];
              end
            end
          end else begin
            d_exp.rdata = model_mem[idx];
          end
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: traffic did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

  initial begin
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    instr_req_i  = 1'b0;
    instr_data_i = '0;
    data_req_i   = 1'b0;
    data_data_i  = '0;
    lcg_state    = 32'd7;
    data_first   = 1'b1;
    i_pend       = 1'b0;
    d_pend       = 1'b0;
    d_chk_rdata  = 1'b0;
    i_exp        = '0;
    d_exp        = '0;
    cycle_cnt    = 0;
    n_conflicts  = 0;
    n_oor        = 0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    // Quiet bus, monitor expects no grant and no rvalid
    repeat (IDLE_CYCLES) @(posedge clk_i);
    run_traffic(0, `MEM_WORDS, 1'b1);
    run_traffic(RAND_REQS, RAND_REQS, 1'b0);
    repeat (4) @(posedge clk_i);

    if (n_conflicts == 0 || n_oor == 0) begin
      $display("Traffic never hit an arbitration conflict or an out-of-range address");
      $display("TESTBENCH FAILED");
      $fatal(1);
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule
